// File: Bender.yml
package:
  name: cache

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/cache_pkg.sv
      - hw/cache_ram.sv
      - hw/lookup_decode.sv
      - hw/cache_ctrl.sv
      - hw/cache_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/mem_model.sv
      - tests/tb_cache.sv

// File: build.f
+incdir+hw
hw/cache_pkg.sv
hw/cache_ram.sv
hw/lookup_decode.sv
hw/cache_ctrl.sv
hw/cache_top.sv
tests/mem_model.sv
tests/tb_cache.sv

// File: hw/cache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module cache_ctrl (
  input  wire logic                  clk,
  input  wire logic                  reset,
  output logic                       cpu_req_ready,
  output logic                       cpu_resp_valid,
  output cache_pkg::word_t           cpu_resp_data,
  input  wire cache_pkg::word_addr_t req_addr,
  input  wire cache_pkg::word_t      req_data,
  input  wire logic                  req_write,
  input  wire logic                  hit,
  input  wire logic                  evict_needed,
  input  wire cache_pkg::tag_t       victim_tag,
  input  wire logic                  decision_valid,
  output logic                       set_valid,
  output logic                       set_dirty,
  output logic                       fill_done,
  output logic [`WORDS_PER_BEAT-1:0] lane_en,
  output logic [`WORDS_PER_BEAT-1:0] lane_we,
  output cache_pkg::lane_idx_t       lane_addr,
  output cache_pkg::beat_t           lane_wdata,
  input  wire cache_pkg::beat_t      lane_rdata,
  output logic                       mem_req_valid,
  input  wire logic                  mem_req_ready,
  output cache_pkg::beat_addr_t      mem_req_addr,
  output logic                       mem_req_rw,
  output logic                       mem_req_data_valid,
  input  wire logic                  mem_req_data_ready,
  output cache_pkg::beat_t           mem_req_data_bits,
  input  wire logic                  mem_resp_valid,
  input  wire cache_pkg::beat_t      mem_resp_data
);

  cache_pkg::ctrl_state_t     state;
  cache_pkg::ctrl_state_t     state_next;
  cache_pkg::beat_idx_t       beat_cnt;
  cache_pkg::beat_idx_t       beat_next;
  cache_pkg::set_idx_t        req_set;
  cache_pkg::word_sel_t       word_sel;
  cache_pkg::tag_t            line_tag;
  cache_pkg::word_t           sel_word;
  logic [`CACHE_SETS-1:0]     valid_q;
  logic [`CACHE_SETS-1:0]     dirty_q;
  logic [`WORDS_PER_BEAT-1:0] word_lane;
  logic                       last_beat;
  logic                       req_pend;
  logic                       data_pend;
  logic                       beat_done;
  logic                       issue_req;
  logic                       issue_data;
  logic                       mark_dirty;

  assign req_set   = cache_pkg::set_of(req_addr);
  assign word_sel  = cache_pkg::word_sel_of(req_addr);
  assign word_lane = `WORDS_PER_BEAT'(1) << word_sel;  // One-hot lane of the addressed word
  assign sel_word  = lane_rdata[word_sel*`WORD_BITS +: `WORD_BITS];
  assign beat_next = beat_cnt + 1'b1;
  assign last_beat = beat_cnt == cache_pkg::beat_idx_t'(`BEATS_PER_LINE - 1);

  assign set_valid = valid_q[req_set];
  assign set_dirty = dirty_q[req_set];

  assign cpu_req_ready  = (state == cache_pkg::IDLE) & ~decision_valid;
  assign cpu_resp_valid = state == cache_pkg::RESPOND;

  // Each valid drops on its own handshake, a write-back beat ends when both are done
  assign req_pend  = mem_req_valid & ~mem_req_ready;
  assign data_pend = mem_req_data_valid & ~mem_req_data_ready;
  assign beat_done = ~req_pend & ~data_pend;

  assign mem_req_rw        = state == cache_pkg::EVICT;
  assign line_tag          = mem_req_rw ? victim_tag : cache_pkg::tag_of(req_addr);
  assign mem_req_addr      = {line_tag, req_set, beat_cnt};
  assign mem_req_data_bits = lane_rdata;  // Lanes stay idle while a beat waits

  always_comb begin
    state_next = state;
    lane_en    = '0;
    lane_we    = '0;
    lane_addr  = {req_set, cache_pkg::beat_of(req_addr)};
    lane_wdata = {`WORDS_PER_BEAT{req_data}};
    issue_req  = 1'b0;
    issue_data = 1'b0;
    mark_dirty = 1'b0;
    fill_done  = 1'b0;
    case (state)
      cache_pkg::IDLE: begin
        if (!decision_valid) begin
          lane_en = '1;  // Read alongside the tag lookup
        end else if (hit) begin
          if (req_write) begin
            lane_en    = word_lane;
            lane_we    = word_lane;
            mark_dirty = 1'b1;
          end
          state_next = cache_pkg::RESPOND;
        end else if (evict_needed) begin
          // First old beat comes out of the lanes with the request
          lane_en    = '1;
          lane_addr  = {req_set, cache_pkg::beat_idx_t'(0)};
          issue_req  = 1'b1;
          issue_data = 1'b1;
          state_next = cache_pkg::EVICT;
        end else begin
          issue_req  = 1'b1;
          state_next = cache_pkg::FETCH_REQ;
        end
      end
      cache_pkg::LOOKUP: begin
        if (req_write) begin
          lane_en    = word_lane;
          lane_we    = word_lane;
          mark_dirty = 1'b1;
          state_next = cache_pkg::RESPOND;
        end else begin
          lane_en    = '1;
          state_next = cache_pkg::READ;
        end
      end
      cache_pkg::READ: begin
        state_next = cache_pkg::RESPOND;
      end
      cache_pkg::RESPOND: begin
        state_next = cache_pkg::IDLE;
      end
      cache_pkg::EVICT: begin
        if (beat_done) begin
          issue_req = 1'b1;  // Next write-back beat, or fetch of beat 0
          if (last_beat) begin
            state_next = cache_pkg::FETCH_REQ;
          end else begin
            lane_en    = '1;
            lane_addr  = {req_set, beat_next};
            issue_data = 1'b1;
          end
        end
      end
      cache_pkg::FETCH_REQ: begin
        if (mem_req_ready) begin
          state_next = cache_pkg::FETCH_WAIT;
        end
      end
      cache_pkg::FETCH_WAIT: begin
        if (mem_resp_valid) begin
          lane_en    = '1;
          lane_we    = '1;
          lane_addr  = {req_set, beat_cnt};
          lane_wdata = mem_resp_data;
          if (last_beat) begin
            fill_done  = 1'b1;
            state_next = cache_pkg::LOOKUP;
          end else begin
            issue_req  = 1'b1;
            state_next = cache_pkg::FETCH_REQ;
          end
        end
      end
      default: begin
        state_next = cache_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state              <= cache_pkg::IDLE;
      beat_cnt           <= '0;
      valid_q            <= '0;
      dirty_q            <= '0;
      mem_req_valid      <= 1'b0;
      mem_req_data_valid <= 1'b0;
    end else begin
      state              <= state_next;
      mem_req_valid      <= issue_req | req_pend;
      mem_req_data_valid <= issue_data | data_pend;
      // Wraps back to 0 after beat 3 of each sequence
      if ((state == cache_pkg::EVICT && beat_done) ||
          (state == cache_pkg::FETCH_WAIT && mem_resp_valid)) begin
        beat_cnt <= beat_next;
      end
      if (fill_done) begin
        valid_q[req_set] <= 1'b1;
        dirty_q[req_set] <= 1'b0;  // Fresh line matches memory
      end else if (mark_dirty) begin
        dirty_q[req_set] <= 1'b1;
      end
    end
  end

  // Response word, meaningless for writes
  always_ff @(posedge clk) begin
    if (state_next == cache_pkg::RESPOND) begin
      cpu_resp_data <= sel_word;
    end
  end

endmodule

`default_nettype wire

// File: hw/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Cache geometry
`define CACHE_SETS      8
`define BEATS_PER_LINE  4  // Beats in one 64-byte line
`define WORDS_PER_BEAT  4

// Data and address widths
`define WORD_BITS       32
`define WORD_ADDR_BITS  30   // CPU addresses count words, not bytes
`define BEAT_BITS       128  // One memory beat holds WORDS_PER_BEAT words

`endif

// File: hw/cache_pkg.sv
`default_nettype none

`include "cache_defs.svh"

package cache_pkg;

  // Word address split, from the low end: word in beat, beat in line, set, tag
  localparam int WORD_SEL_BITS = $clog2(`WORDS_PER_BEAT);
  localparam int BEAT_IDX_BITS = $clog2(`BEATS_PER_LINE);
  localparam int SET_IDX_BITS  = $clog2(`CACHE_SETS);
  localparam int TAG_BITS      = `WORD_ADDR_BITS - SET_IDX_BITS - BEAT_IDX_BITS - WORD_SEL_BITS;

  typedef logic [`WORD_BITS-1:0]                     word_t;
  typedef logic [`BEAT_BITS-1:0]                     beat_t;
  typedef logic [`WORD_ADDR_BITS-1:0]                word_addr_t;
  typedef logic [`WORD_ADDR_BITS-WORD_SEL_BITS-1:0]  beat_addr_t;
  typedef logic [WORD_SEL_BITS-1:0]                  word_sel_t;
  typedef logic [BEAT_IDX_BITS-1:0]                  beat_idx_t;
  typedef logic [SET_IDX_BITS-1:0]                   set_idx_t;
  typedef logic [TAG_BITS-1:0]                       tag_t;
  typedef logic [SET_IDX_BITS+BEAT_IDX_BITS-1:0]     lane_idx_t;  // Row of a word-lane RAM

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,      // Line resident after a fill, pending access goes ahead
    READ,
    RESPOND,
    EVICT,
    FETCH_REQ,
    FETCH_WAIT
  } ctrl_state_t;

  function automatic word_sel_t word_sel_of(word_addr_t addr);
    return addr[WORD_SEL_BITS-1:0];
  endfunction

  function automatic beat_idx_t beat_of(word_addr_t addr);
    return addr[WORD_SEL_BITS +: BEAT_IDX_BITS];
  endfunction

  function automatic set_idx_t set_of(word_addr_t addr);
    return addr[WORD_SEL_BITS+BEAT_IDX_BITS +: SET_IDX_BITS];
  endfunction

  function automatic tag_t tag_of(word_addr_t addr);
    return addr[`WORD_ADDR_BITS-1 -: TAG_BITS];
  endfunction

endpackage

`default_nettype wire

// File: hw/cache_ram.sv
`timescale 1ns/100ps
`default_nettype none

module cache_ram #(
  parameter type entry_t = logic,
  parameter int  DEPTH   = 8
) (
  input  wire logic                     clk,
  input  wire logic                     en,
  input  wire logic                     we,
  input  wire logic [$clog2(DEPTH)-1:0] addr,
  input  wire entry_t                   wdata,
  output entry_t                        rdata
);

  entry_t mem [DEPTH];

  // Registered read. A write or an idle cycle leaves rdata holding the last read
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rdata <= mem[addr];
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/cache_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module cache_top (
  input  wire logic                  clk,
  input  wire logic                  reset,

  input  wire logic                  cpu_req_valid,
  output logic                       cpu_req_ready,
  input  wire cache_pkg::word_addr_t cpu_req_addr,
  input  wire cache_pkg::word_t      cpu_req_data,
  input  wire logic                  cpu_req_write,
  output logic                       cpu_resp_valid,
  output cache_pkg::word_t           cpu_resp_data,

  output logic                       mem_req_valid,
  input  wire logic                  mem_req_ready,
  output cache_pkg::beat_addr_t      mem_req_addr,
  output logic                       mem_req_rw,
  output logic                       mem_req_data_valid,
  input  wire logic                  mem_req_data_ready,
  output cache_pkg::beat_t           mem_req_data_bits,
  input  wire logic                  mem_resp_valid,
  input  wire cache_pkg::beat_t      mem_resp_data
);

  // Decode to controller
  cache_pkg::word_addr_t req_addr;
  cache_pkg::word_t      req_data;
  logic                  req_write;
  logic                  hit;
  logic                  evict_needed;
  cache_pkg::tag_t       victim_tag;
  logic                  decision_valid;

  // Controller to decode
  logic set_valid;
  logic set_dirty;
  logic fill_done;

  // Word-lane RAM ports
  logic [`WORDS_PER_BEAT-1:0] lane_en;
  logic [`WORDS_PER_BEAT-1:0] lane_we;
  cache_pkg::lane_idx_t       lane_addr;
  cache_pkg::beat_t           lane_wdata;
  wire cache_pkg::beat_t      lane_rdata;  // One slice per lane

  lookup_decode u_lookup_decode (
    .clk            (clk),
    .reset          (reset),
    .cpu_req_valid  (cpu_req_valid),
    .cpu_req_ready  (cpu_req_ready),
    .cpu_req_addr   (cpu_req_addr),
    .cpu_req_data   (cpu_req_data),
    .cpu_req_write  (cpu_req_write),
    .set_valid      (set_valid),
    .set_dirty      (set_dirty),
    .fill_done      (fill_done),
    .req_addr       (req_addr),
    .req_data       (req_data),
    .req_write      (req_write),
    .hit            (hit),
    .evict_needed   (evict_needed),
    .victim_tag     (victim_tag),
    .decision_valid (decision_valid)
  );

  cache_ctrl u_cache_ctrl (
    .clk                (clk),
    .reset              (reset),
    .cpu_req_ready      (cpu_req_ready),
    .cpu_resp_valid     (cpu_resp_valid),
    .cpu_resp_data      (cpu_resp_data),
    .req_addr           (req_addr),
    .req_data           (req_data),
    .req_write          (req_write),
    .hit                (hit),
    .evict_needed       (evict_needed),
    .victim_tag         (victim_tag),
    .decision_valid     (decision_valid),
    .set_valid          (set_valid),
    .set_dirty          (set_dirty),
    .fill_done          (fill_done),
    .lane_en            (lane_en),
    .lane_we            (lane_we),
    .lane_addr          (lane_addr),
    .lane_wdata         (lane_wdata),
    .lane_rdata         (lane_rdata),
    .mem_req_valid      (mem_req_valid),
    .mem_req_ready      (mem_req_ready),
    .mem_req_addr       (mem_req_addr),
    .mem_req_rw         (mem_req_rw),
    .mem_req_data_valid (mem_req_data_valid),
    .mem_req_data_ready (mem_req_data_ready),
    .mem_req_data_bits  (mem_req_data_bits),
    .mem_resp_valid     (mem_resp_valid),
    .mem_resp_data      (mem_resp_data)
  );

  // Lane i holds word i of every beat
  for (genvar i = 0; i < `WORDS_PER_BEAT; i++) begin : g_lane
    cache_ram #(
      .entry_t (cache_pkg::word_t),
      .DEPTH   (`CACHE_SETS * `BEATS_PER_LINE)
    ) u_lane_ram (
      .clk   (clk),
      .en    (lane_en[i]),
      .we    (lane_we[i]),
      .addr  (lane_addr),
      .wdata (lane_wdata[i*`WORD_BITS +: `WORD_BITS]),
      .rdata (lane_rdata[i*`WORD_BITS +: `WORD_BITS])
    );
  end

endmodule

`default_nettype wire

// File: hw/lookup_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module lookup_decode (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  cpu_req_valid,
  input  wire logic                  cpu_req_ready,
  input  wire cache_pkg::word_addr_t cpu_req_addr,
  input  wire cache_pkg::word_t      cpu_req_data,
  input  wire logic                  cpu_req_write,
  input  wire logic                  set_valid,
  input  wire logic                  set_dirty,
  input  wire logic                  fill_done,
  output cache_pkg::word_addr_t      req_addr,
  output cache_pkg::word_t           req_data,
  output logic                       req_write,
  output logic                       hit,
  output logic                       evict_needed,
  output cache_pkg::tag_t            victim_tag,
  output logic                       decision_valid
);

  logic                  accept;
  logic                  tag_match;
  cache_pkg::word_addr_t addr_q;

  assign accept = cpu_req_valid & cpu_req_ready;

  // Request capture
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q    <= cpu_req_addr;
      req_data  <= cpu_req_data;
      req_write <= cpu_req_write;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      decision_valid <= 1'b0;
    end else begin
      decision_valid <= accept;  // Stored tag is out one cycle after accept
    end
  end

  // Live CPU address while ready, so the lane RAMs can read in step with the tag RAM
  assign req_addr = cpu_req_ready ? cpu_req_addr : addr_q;

  // Tag array, read on accept and written with the new tag as a fill ends
  cache_ram #(
    .entry_t (cache_pkg::tag_t),
    .DEPTH   (`CACHE_SETS)
  ) u_tag_ram (
    .clk   (clk),
    .en    (accept | fill_done),
    .we    (fill_done),
    .addr  (cache_pkg::set_of(req_addr)),
    .wdata (cache_pkg::tag_of(req_addr)),
    .rdata (victim_tag)  // Holds through the miss, so it doubles as the write-back tag
  );

  assign tag_match = victim_tag == cache_pkg::tag_of(addr_q);

  // Hit needs the set valid, write-back needs valid and dirty on a tag mismatch
  assign hit          = set_valid & tag_match;
  assign evict_needed = set_valid & set_dirty & ~tag_match;

endmodule

`default_nettype wire

// File: tests/mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module mem_model (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  mem_req_valid,
  output logic                       mem_req_ready,
  input  wire cache_pkg::beat_addr_t mem_req_addr,
  input  wire logic                  mem_req_rw,
  input  wire logic                  mem_req_data_valid,
  output logic                       mem_req_data_ready,
  input  wire cache_pkg::beat_t      mem_req_data_bits,
  output logic                       mem_resp_valid,
  output cache_pkg::beat_t           mem_resp_data
);

  cache_pkg::beat_t      mem [cache_pkg::beat_addr_t];  // Only beats written back so far
  cache_pkg::beat_addr_t wr_addr_q [$];
  cache_pkg::beat_t      wr_data_q [$];
  cache_pkg::beat_addr_t rd_addr;
  int                    rd_delay;
  bit                    rd_pending;

  // Low half repeated in the upper half, folded with the high address bits
  function automatic cache_pkg::beat_t initial_beat(cache_pkg::beat_addr_t baddr);
    cache_pkg::word_addr_t waddr;
    cache_pkg::beat_t      beat;
    for (int i = 0; i < 4; i++) begin
      waddr = {baddr, 2'(i)};
      beat[i*32 +: 32] = {waddr[15:0] ^ {2'b00, waddr[29:16]}, waddr[15:0]};
    end
    return beat;
  endfunction

  initial begin
    mem_req_ready      = 1'b0;
    mem_req_data_ready = 1'b0;
    mem_resp_valid     = 1'b0;
    mem_resp_data      = '0;
    rd_pending         = 1'b0;
    rd_delay           = 0;
  end

  // Handshakes seen at the rising edge
  always @(posedge clk) begin
    if (!reset) begin
      if (mem_req_valid && mem_req_ready) begin
        if (mem_req_rw) begin
          wr_addr_q.push_back(mem_req_addr);
        end else begin
          rd_addr    = mem_req_addr;
          rd_delay   = 1 + $urandom_range(3);  // Answer after 1 to 4 cycles
          rd_pending = 1'b1;
        end
      end
      if (mem_req_data_valid && mem_req_data_ready) begin
        wr_data_q.push_back(mem_req_data_bits);
      end
      while (wr_addr_q.size() > 0 && wr_data_q.size() > 0) begin
        mem[wr_addr_q.pop_front()] = wr_data_q.pop_front();  // Pair address and data in order
      end
    end
  end

  // Outputs change on the falling edge
  always @(negedge clk) begin
    mem_resp_valid = 1'b0;
    if (reset) begin
      mem_req_ready      = 1'b0;
      mem_req_data_ready = 1'b0;
      rd_pending         = 1'b0;
    end else begin
      mem_req_ready      = $urandom_range(3) != 0;  // Stall about one cycle in four
      mem_req_data_ready = $urandom_range(3) != 0;
      if (rd_pending) begin
        rd_delay--;
        if (rd_delay == 0) begin
          rd_pending     = 1'b0;
          mem_resp_valid = 1'b1;
          mem_resp_data  = mem.exists(rd_addr) ? mem[rd_addr] : initial_beat(rd_addr);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_cache.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module tb_cache;

  localparam int NUM_OPS       = 400;
  localparam int BATCH_OPS     = 100;
  localparam int CYCLES_PER_OP = 60;
  localparam int MAX_CYCLES    = NUM_OPS * CYCLES_PER_OP;

  logic                  clk;
  logic                  reset;
  logic                  cpu_req_valid;
  logic                  cpu_req_ready;
  cache_pkg::word_addr_t cpu_req_addr;
  cache_pkg::word_t      cpu_req_data;
  logic                  cpu_req_write;
  logic                  cpu_resp_valid;
  cache_pkg::word_t      cpu_resp_data;
  logic                  mem_req_valid;
  logic                  mem_req_ready;
  cache_pkg::beat_addr_t mem_req_addr;
  logic                  mem_req_rw;
  logic                  mem_req_data_valid;
  logic                  mem_req_data_ready;
  cache_pkg::beat_t      mem_req_data_bits;
  logic                  mem_resp_valid;
  cache_pkg::beat_t      mem_resp_data;

  // Reference word memory and cache model
  cache_pkg::word_t      ref_mem [cache_pkg::word_addr_t];
  cache_pkg::tag_t       model_tag [`CACHE_SETS];
  logic                  model_valid [`CACHE_SETS];
  logic                  model_dirty [`CACHE_SETS];
  cache_pkg::tag_t       tag_pool [4];

  // Memory traffic seen during one operation
  cache_pkg::beat_addr_t req_addr_q [$];
  logic                  req_rw_q [$];
  cache_pkg::beat_t      wdata_q [$];

  int cycles;
  int checks;
  int errors;
  int hits;
  int clean_misses;
  int dirty_misses;

  cache_top u_cache_top (.*);

  mem_model u_mem_model (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the cache stopped answering", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic cache_pkg::word_t ref_word(cache_pkg::word_addr_t addr);
    if (ref_mem.exists(addr)) begin
      return ref_mem[addr];
    end
    return {addr[15:0] ^ {2'b00, addr[29:16]}, addr[15:0]};
  endfunction

  function automatic cache_pkg::beat_t ref_beat(cache_pkg::beat_addr_t baddr);
    cache_pkg::beat_t beat;
    for (int i = 0; i < 4; i++) begin
      beat[i*32 +: 32] = ref_word({baddr, 2'(i)});  // Word i sits in lane i
    end
    return beat;
  endfunction

  task automatic compare_bit(input string name, input string when,
                             input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch %s %s: got %h, expected %h", name, when, got, exp);
      errors++;
    end
  endtask

  task automatic check_idle_outputs(input string when);
    compare_bit("cpu_req_ready", when, cpu_req_ready, 1'b1);
    compare_bit("cpu_resp_valid", when, cpu_resp_valid, 1'b0);
    compare_bit("mem_req_valid", when, mem_req_valid, 1'b0);
    compare_bit("mem_req_data_valid", when, mem_req_data_valid, 1'b0);
  endtask

  task automatic run_op(input int op, input cache_pkg::word_addr_t addr,
                        input cache_pkg::word_t data, input logic write);
    cache_pkg::set_idx_t   set;
    cache_pkg::tag_t       tag;
    cache_pkg::tag_t       old_tag;
    cache_pkg::beat_addr_t exp_addr;
    logic                  exp_hit;
    logic                  exp_evict;
    logic                  exp_rw;
    int                    n_exp;
    int                    lat;
    set       = addr[6:4];
    tag       = addr[29:7];
    old_tag   = model_tag[set];
    exp_hit   = model_valid[set] && old_tag == tag;
    exp_evict = model_valid[set] && model_dirty[set] && !exp_hit;
    n_exp     = exp_hit ? 0 : (exp_evict ? 8 : 4);
    req_addr_q.delete();
    req_rw_q.delete();
    wdata_q.delete();
    @(negedge clk);
    cpu_req_valid = 1'b1;
    cpu_req_addr  = addr;
    cpu_req_data  = data;
    cpu_req_write = write;
    do @(posedge clk); while (!cpu_req_ready);
    @(negedge clk);
    cpu_req_valid = 1'b0;
    lat = 1;
    forever begin
      if (lat > 1) @(negedge clk);
      @(posedge clk);
      if (mem_req_valid && mem_req_ready) begin
        req_addr_q.push_back(mem_req_addr);
        req_rw_q.push_back(mem_req_rw);
      end
      if (mem_req_data_valid && mem_req_data_ready) wdata_q.push_back(mem_req_data_bits);
      if (cpu_resp_valid) break;
      checks++;
      if (cpu_req_ready) begin
        $display("Op %0d: cpu_req_ready rose before the response", op);
        errors++;
      end
      lat++;
    end
    checks++;
    if (!write && cpu_resp_data !== ref_word(addr)) begin
      $display("Mismatch cpu_resp_data at %h: got %h, expected %h",
               addr, cpu_resp_data, ref_word(addr));
      errors++;
    end
    checks++;
    if (exp_hit && lat != 2) begin
      $display("Op %0d: hit answered %0d cycles after accept instead of 2", op, lat);
      errors++;
    end
    checks++;
    if (req_addr_q.size() != n_exp || wdata_q.size() != (exp_evict ? 4 : 0)) begin
      $display("Op %0d: expected %0d memory requests, saw %0d with %0d data beats",
               op, n_exp, req_addr_q.size(), wdata_q.size());
      errors++;
    end else begin
      for (int i = 0; i < n_exp; i++) begin
        exp_rw   = exp_evict && i < 4;  // Write-back beats come before the fetch
        exp_addr = exp_rw ? {old_tag, set, 2'(i)} : {tag, set, 2'(i % 4)};
        checks++;
        if (req_rw_q[i] !== exp_rw || req_addr_q[i] !== exp_addr) begin
          $display("Mismatch mem_req_addr op %0d beat %0d: got %h rw %h, expected %h rw %h",
                   op, i, req_addr_q[i], req_rw_q[i], exp_addr, exp_rw);
          errors++;
        end
      end
      for (int i = 0; i < wdata_q.size(); i++) begin
        checks++;
        if (wdata_q[i] !== ref_beat({old_tag, set, 2'(i)})) begin
          $display("Mismatch mem_req_data_bits op %0d beat %0d: got %h, expected %h",
                   op, i, wdata_q[i], ref_beat({old_tag, set, 2'(i)}));
          errors++;
        end
      end
    end
    @(negedge clk);
    @(posedge clk);
    checks++;
    if (cpu_resp_valid) begin
      $display("Op %0d: a second response followed the first", op);
      errors++;
    end
    // Model update
    if (exp_hit) hits++;
    else if (exp_evict) dirty_misses++;
    else clean_misses++;
    if (!exp_hit) begin
      model_tag[set]   = tag;
      model_valid[set] = 1'b1;
      model_dirty[set] = 1'b0;
    end
    if (write) begin
      ref_mem[addr]    = data;
      model_dirty[set] = 1'b1;
    end
  endtask

  initial begin
    cache_pkg::word_addr_t addr;
    int                    batch_errors;
    void'($urandom(61));
    reset         = 1'b1;
    cpu_req_valid = 1'b0;
    cpu_req_addr  = '0;
    cpu_req_data  = '0;
    cpu_req_write = 1'b0;
    cycles        = 0;
    checks        = 0;
    errors        = 0;
    hits          = 0;
    clean_misses  = 0;
    dirty_misses  = 0;
    tag_pool      = '{23'h000000, 23'h000001, 23'h0002a5, 23'h07f0c3};
    for (int s = 0; s < `CACHE_SETS; s++) begin
      model_valid[s] = 1'b0;
      model_dirty[s] = 1'b0;
      model_tag[s]   = '0;
    end
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      if (i > 0) check_idle_outputs("during reset");  // First edge still sees unreset state
    end
    @(negedge clk);
    reset = 1'b0;
    @(posedge clk);
    check_idle_outputs("after reset");
    $display("reset: %0d errors", errors);
    for (int b = 0; b < NUM_OPS / BATCH_OPS; b++) begin
      batch_errors = errors;
      for (int i = 0; i < BATCH_OPS; i++) begin
        addr = {tag_pool[$urandom_range(3)], 3'($urandom_range(7)), 4'($urandom_range(15))};
        run_op(b * BATCH_OPS + i, addr, $urandom, $urandom_range(1));
      end
      $display("batch %0d: %0d ops done, %0d errors", b, BATCH_OPS, errors - batch_errors);
    end
    $display("ops %0d, hits %0d, clean misses %0d, dirty misses %0d, checks %0d, errors %0d",
             NUM_OPS, hits, clean_misses, dirty_misses, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
